// ==== mem_traffic_top.f ====
logic/traffic_pkg.sv
logic/run_control.sv
logic/addr_gen.sv
logic/write_data_gen.sv
logic/request_port.sv
logic/tag_checker.sv
logic/mem_traffic_top.sv
bench/tb_clock.sv
bench/mem_traffic_chk.sv
bench/mem_traffic_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build the testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f mem_traffic_top.f --top-module mem_traffic_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vmem_traffic_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
exit 1

// ==== bench/mem_traffic_tb.sv ====
// Testbench with memory model, run stimulus, tag reference and checks
`timescale 1ns/1ps

module mem_traffic_tb import traffic_pkg::*;
();

    localparam int MAX_CYCLES = 6000;
    localparam int RUN_LEN = 500;
    localparam line_addr_t BASE = 32'h0004_0000;
    localparam line_addr_t STATUS = 32'h0005_0000;

    logic clk, reset, start;
    counter_t run_cycles;
    logic enable_reads, enable_writes, enable_checker, enable_rw_conflicts;
    line_addr_t mem_base, status_addr;
    logic rd_req_valid, rd_req_checked, rd_almost_full, rd_rsp_valid, rd_rsp_checked;
    line_addr_t rd_req_addr, wr_req_addr;
    line_data_t rd_rsp_data, wr_req_data;
    logic wr_req_valid, wr_almost_full, wr_rsp_valid, run_busy;
    counter_t cnt_rd_rsp, cnt_wr_rsp, cnt_checked_rd;

    // Model state
    line_data_t mem [4096];
    line_data_t rd_q_data [$];
    logic rd_q_chk [$];
    int rd_q_due [$];
    int cycle, errors, rd_rsp_cnt, wr_rsp_cnt, chk_rsp_cnt, mismatches;
    int status_seen, run_age;
    line_data_t status_data;
    logic reset_q, start_q, rd_af_q, wr_af_q;
    logic started, conflicts_off, inject_armed;

    tb_clock clk0 (.clk);

    mem_traffic_top dut0 (.*);

    // Expected tag, byte 15 on top down to byte 0
    function automatic logic [31:0] tag_of(input line_data_t line);
        return {line[127:120], line[95:88], line[47:40], line[7:0]};
    endfunction

    task automatic report_value(input string name, input logic [127:0] exp,
                                input logic [127:0] got);
        errors++;
        $display("Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic report_text(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // Watchdog and posedge copies of driven levels
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        reset_q <= reset;
        start_q <= start;
        rd_af_q <= rd_almost_full;
        wr_af_q <= wr_almost_full;
        if (cycle >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the runs did not complete", cycle);
            $display("Simulation failed");
            $finish;
        end
    end

    // ========================================================================
    // Memory model and comparing process
    // ========================================================================

    always @(negedge clk)
    begin : model
        line_addr_t off;
        line_data_t d;
        line_data_t orig;
        logic c;

        if (start_q)
        begin
            rd_rsp_cnt = 0;
            wr_rsp_cnt = 0;
            chk_rsp_cnt = 0;
            mismatches = 0;
            status_seen = 0;
            run_age = 0;
        end
        rd_rsp_valid = 1'b0;
        wr_rsp_valid = 1'b0;
        if (!reset_q)
        begin
            if (run_busy)
            begin
                run_age++;
            end
            if (!started && (rd_req_valid || wr_req_valid || run_busy))
            begin
                report_text("activity seen before the first start");
            end
            if (rd_af_q && rd_req_valid)
            begin
                report_text("read request while rd_almost_full was high");
            end
            if (wr_af_q && wr_req_valid)
            begin
                report_text("write request while wr_almost_full was high");
            end
            // Read takes the line before any write of the same cycle
            if (rd_req_valid)
            begin
                off = rd_req_addr - mem_base;
                if (off >= 4096)
                begin
                    report_value("rd_req_addr offset", 4095, off);
                end
                if (conflicts_off && off[0] != 1'b0)
                begin
                    report_value("rd_req_addr bit 0", 0, off[0]);
                end
                // Checked lines have a zero middle field
                if (rd_req_checked != (off[8:5] == 4'd0))
                begin
                    report_value("rd_req_checked", off[8:5] == 4'd0, rd_req_checked);
                end
                rd_q_data.push_back(mem[off[11:0]]);
                rd_q_chk.push_back(rd_req_checked);
                rd_q_due.push_back(cycle + 2 + int'($urandom_range(0, 4)));
            end
            if (wr_req_valid)
            begin
                wr_rsp_valid = 1'b1;
                wr_rsp_cnt++;
                if (wr_req_addr == status_addr)
                begin
                    status_seen++;
                    status_data = wr_req_data;
                end
                else
                begin
                    off = wr_req_addr - mem_base;
                    if (off >= 4096)
                    begin
                        report_value("wr_req_addr offset", 4095, off);
                    end
                    if (conflicts_off && off[0] != 1'b1)
                    begin
                        report_value("wr_req_addr bit 0", 1, off[0]);
                    end
                    mem[off[11:0]] = wr_req_data;
                end
            end
            // In-order responses, one per cycle
            if (rd_q_due.size() > 0 && rd_q_due[0] <= cycle)
            begin
                void'(rd_q_due.pop_front());
                d = rd_q_data.pop_front();
                c = rd_q_chk.pop_front();
                orig = d;
                if (c && inject_armed && run_age > 20 && run_age < 300)
                begin
                    inject_armed = 1'b0;
                    d[7:0] = ~d[7:0];
                end
                // Tag of the returned line against the tag held at issue
                if (c && tag_of(d) != tag_of(orig))
                begin
                    mismatches++;
                end
                rd_rsp_valid = 1'b1;
                rd_rsp_data = d;
                rd_rsp_checked = c;
                rd_rsp_cnt++;
                if (c)
                begin
                    chk_rsp_cnt++;
                end
            end
        end
    end

    // ========================================================================
    // Runs
    // ========================================================================

    task automatic do_run(input logic checker_en, input logic conflicts_en,
                          input logic inject, input logic backpressure);
        int exp_status;

        conflicts_off = !conflicts_en;
        inject_armed = inject;
        run_cycles = RUN_LEN;
        enable_reads = 1'b1;
        enable_writes = 1'b1;
        enable_checker = checker_en;
        enable_rw_conflicts = conflicts_en;
        started = 1'b1;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (backpressure)
        begin
            // Window straddles the end of the run
            repeat (RUN_LEN - 20) @(negedge clk);
            rd_almost_full = 1'b1;
            wr_almost_full = 1'b1;
            repeat (40) @(negedge clk);
            if (status_seen != 0)
            begin
                report_text("status write issued while wr_almost_full was high");
            end
            if (!run_busy)
            begin
                report_text("run ended before wr_almost_full fell");
            end
            rd_almost_full = 1'b0;
            wr_almost_full = 1'b0;
        end
        while (run_busy)
        begin
            @(negedge clk);
        end
        while (rd_q_due.size() > 0)
        begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        if (inject && inject_armed)
        begin
            report_text("no checked response was available for corruption");
        end
        exp_status = (checker_en && mismatches > 0) ? 2 : 1;
        if (status_seen != 1)
        begin
            report_value("status write count", 1, status_seen);
        end
        if (status_data != line_data_t'(exp_status))
        begin
            report_value("status data", exp_status, status_data);
        end
        if (cnt_rd_rsp != counter_t'(rd_rsp_cnt))
        begin
            report_value("cnt_rd_rsp", rd_rsp_cnt, cnt_rd_rsp);
        end
        if (cnt_wr_rsp != counter_t'(wr_rsp_cnt))
        begin
            report_value("cnt_wr_rsp", wr_rsp_cnt, cnt_wr_rsp);
        end
        // Pairs still in flight when RUN ends are not counted
        if (cnt_checked_rd > counter_t'(chk_rsp_cnt) || cnt_checked_rd + 12 < chk_rsp_cnt)
        begin
            report_value("cnt_checked_rd", chk_rsp_cnt, cnt_checked_rd);
        end
    endtask

    initial
    begin
        void'($urandom(32'h443));
        foreach (mem[i])
        begin
            mem[i] = '0;
        end
        cycle = 0;
        errors = 0;
        status_seen = 0;
        status_data = '0;
        started = 1'b0;
        conflicts_off = 1'b0;
        inject_armed = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        run_cycles = '0;
        enable_reads = 1'b0;
        enable_writes = 1'b0;
        enable_checker = 1'b0;
        enable_rw_conflicts = 1'b0;
        mem_base = BASE;
        status_addr = STATUS;
        rd_almost_full = 1'b0;
        wr_almost_full = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp_checked = 1'b0;
        rd_rsp_data = '0;
        wr_rsp_valid = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // Quiet after reset while the tag RAM clears
        repeat (300) @(negedge clk);

        do_run(1'b1, 1'b0, 1'b1, 1'b0);
        do_run(1'b0, 1'b0, 1'b1, 1'b0);
        do_run(1'b1, 1'b1, 1'b0, 1'b1);

        $display("Errors: %0d", errors);
        if (errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== bench/mem_traffic_chk.sv ====
// Bound assertions on back-pressure, index bit 0 split and status data
`timescale 1ns/1ps

module mem_traffic_chk import traffic_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       rd_almost_full,
    input logic       wr_almost_full,
    input logic       rd_req_valid,
    input logic       wr_req_valid,
    input line_addr_t rd_req_addr,
    input line_addr_t wr_req_addr,
    input line_data_t wr_req_data,
    input line_addr_t mem_base,
    input line_addr_t status_addr,
    input logic       rw_conflicts
);

    line_addr_t rd_off;
    line_addr_t wr_off;

    assign rd_off = rd_req_addr - mem_base;
    assign wr_off = wr_req_addr - mem_base;

    // ========================================================================
    // Back-pressure
    // ========================================================================

    a_rd_backpressure: assert property (@(posedge clk) disable iff (reset)
        rd_almost_full |=> !rd_req_valid)
        else $error("read request one cycle after rd_almost_full");

    a_wr_backpressure: assert property (@(posedge clk) disable iff (reset)
        wr_almost_full |=> !wr_req_valid)
        else $error("write request one cycle after wr_almost_full");

    // ========================================================================
    // Address split and status line
    // ========================================================================

    // Reads on even indexes, writes on odd ones
    a_rd_even: assert property (@(posedge clk) disable iff (reset)
        (rd_req_valid && !rw_conflicts) |-> (rd_off[0] == 1'b0))
        else $error("read index bit 0 set with conflicts disabled");

    a_wr_odd: assert property (@(posedge clk) disable iff (reset)
        (wr_req_valid && !rw_conflicts && wr_req_addr != status_addr) |-> (wr_off[0] == 1'b1))
        else $error("write index bit 0 clear with conflicts disabled");

    a_status_code: assert property (@(posedge clk) disable iff (reset)
        (wr_req_valid && wr_req_addr == status_addr)
            |-> (wr_req_data == line_data_t'(1) || wr_req_data == line_data_t'(2)))
        else $error("status write with an unknown code");

endmodule

bind mem_traffic_top mem_traffic_chk chk0 (.*);

// ==== bench/tb_clock.sv ====
// Free-running testbench clock with a 100 ns period
`timescale 1ns/1ps

module tb_clock
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    // Half period of 50 ns
    always #50 clk = ~clk;

endmodule

// ==== logic/mem_traffic_top.sv ====
// Top level joining run control, address, data, request and checker blocks
`timescale 1ns/1ps

module mem_traffic_top import traffic_pkg::*;
#(
    parameter int          FIFO_DEPTH = 16,
    parameter logic [31:0] RD_SEED = 32'h2721,
    parameter logic [31:0] WR_SEED = 32'h8520
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  counter_t   run_cycles,
    input  logic       enable_reads,
    input  logic       enable_writes,
    input  logic       enable_checker,
    input  logic       enable_rw_conflicts,
    input  line_addr_t mem_base,
    input  line_addr_t status_addr,
    output logic       rd_req_valid,
    output line_addr_t rd_req_addr,
    output logic       rd_req_checked,
    input  logic       rd_almost_full,
    input  logic       rd_rsp_valid,
    input  line_data_t rd_rsp_data,
    input  logic       rd_rsp_checked,
    output logic       wr_req_valid,
    output line_addr_t wr_req_addr,
    output line_data_t wr_req_data,
    input  logic       wr_almost_full,
    input  logic       wr_rsp_valid,
    output logic       run_busy,
    output counter_t   cnt_rd_rsp,
    output counter_t   cnt_wr_rsp,
    output counter_t   cnt_checked_rd
);

    run_state_e state;
    logic rd_enabled, wr_enabled, checker_enabled, rw_conflicts;
    logic chk_ready, raise_error, chk_wr_valid;
    line_addr_t rd_addr, wr_addr;
    logic rd_checked, wr_checked;
    chk_idx_t rd_chk_idx_q, wr_chk_idx_q;
    line_data_t wr_rand_data;

    run_control ctrl (
        .clk, .reset, .start, .run_cycles, .enable_reads, .enable_writes,
        .enable_checker, .enable_rw_conflicts, .raise_error, .wr_almost_full,
        .state, .rd_enabled, .wr_enabled, .checker_enabled, .rw_conflicts, .run_busy
    );

    // Reads keep index bit 0 low and writes keep it high without conflicts
    addr_gen #(.SEED(RD_SEED), .FORCED_BIT(1'b0)) rd_addr0 (
        .clk, .reset, .mem_base, .rw_conflicts, .addr(rd_addr),
        .addr_checked(rd_checked), .chk_idx(), .chk_idx_q(rd_chk_idx_q)
    );

    addr_gen #(.SEED(WR_SEED), .FORCED_BIT(1'b1)) wr_addr0 (
        .clk, .reset, .mem_base, .rw_conflicts, .addr(wr_addr),
        .addr_checked(wr_checked), .chk_idx(), .chk_idx_q(wr_chk_idx_q)
    );

    write_data_gen data_gen (.clk, .reset, .wr_rand_data);

    request_port req (
        .clk, .reset, .state, .rd_enabled, .wr_enabled, .chk_ready,
        .rd_almost_full, .wr_almost_full, .rd_addr, .rd_checked, .wr_addr,
        .wr_checked, .wr_data(wr_rand_data), .status_addr, .rd_rsp_valid,
        .wr_rsp_valid, .start, .rd_req_valid, .rd_req_addr, .rd_req_checked,
        .wr_req_valid, .wr_req_addr, .wr_req_data, .chk_wr_valid,
        .cnt_rd_rsp, .cnt_wr_rsp
    );

    tag_checker #(.FIFO_DEPTH(FIFO_DEPTH)) tag_chk (
        .clk, .reset, .start, .state, .checker_enabled, .chk_wr_valid,
        .wr_chk_idx_q, .wr_req_data, .rd_req_valid, .rd_req_checked,
        .rd_req_addr, .rd_chk_idx_q, .rd_rsp_valid, .rd_rsp_checked,
        .rd_rsp_data, .chk_ready, .raise_error, .cnt_checked_rd
    );

endmodule

// ==== logic/tag_checker.sv ====
// Tag RAM with clearing pass, read pipeline, matching FIFOs and comparison
`timescale 1ns/1ps

module tag_checker import traffic_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  run_state_e state,
    input  logic       checker_enabled,
    input  logic       chk_wr_valid,
    input  chk_idx_t   wr_chk_idx_q,
    input  line_data_t wr_req_data,
    input  logic       rd_req_valid,
    input  logic       rd_req_checked,
    input  line_addr_t rd_req_addr,
    input  chk_idx_t   rd_chk_idx_q,
    input  logic       rd_rsp_valid,
    input  logic       rd_rsp_checked,
    input  line_data_t rd_rsp_data,
    output logic       chk_ready,
    output logic       raise_error,
    output counter_t   cnt_checked_rd
);

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);
    // Leaves room for requests still in flight when ready drops
    localparam int AF_LEVEL = FIFO_DEPTH - 8;

    tag_t tag_ram [1 << CHECKED_BITS];
    logic clearing;
    chk_idx_t clr_idx;
    tag_t rd_tag_s0, rd_tag_s1, rd_tag_s2;
    logic [2:0] chk_rd_v;
    tag_t enq_data [2];
    tag_t first [2];
    logic [1:0] enq_en;
    logic [1:0] not_empty;
    logic fifo_deq;
    logic chk_almost_full;

    // ========================================================================
    // Tag RAM
    // ========================================================================

    // Zero every entry once after reset
    always_ff @(posedge clk)
    begin
        if (clearing)
        begin
            clr_idx <= clr_idx + chk_idx_t'(1);
            clearing <= (clr_idx != '1);
        end
        if (reset)
        begin
            clearing <= 1'b1;
            clr_idx <= '0;
        end
    end

    // Read before write gives old data on a same-cycle hit
    always_ff @(posedge clk)
    begin
        rd_tag_s0 <= tag_ram[rd_chk_idx_q];
        rd_tag_s1 <= rd_tag_s0;
        rd_tag_s2 <= rd_tag_s1;
        if (clearing)
        begin
            tag_ram[clr_idx] <= '0;
        end
        else if (chk_wr_valid)
        begin
            tag_ram[wr_chk_idx_q] <= line_to_tag(wr_req_data);
        end
    end

    // Flag follows the RAM output stages
    always_ff @(posedge clk)
    begin
        chk_rd_v <= {chk_rd_v[1:0], rd_req_valid && rd_req_checked};
        chk_ready <= !clearing && !chk_almost_full;
        if (reset)
        begin
            chk_rd_v <= '0;
            chk_ready <= 1'b0;
        end
    end

    // ========================================================================
    // Expected tag FIFO (0) and response tag FIFO (1)
    // ========================================================================

    assign enq_en[0] = chk_rd_v[2];
    assign enq_data[0] = rd_tag_s2;
    assign enq_en[1] = rd_rsp_valid && rd_rsp_checked;
    assign enq_data[1] = line_to_tag(rd_rsp_data);
    assign fifo_deq = &not_empty;

    for (genvar f = 0; f < 2; f++)
    begin : fifo
        tag_t mem [FIFO_DEPTH];
        logic [PTR_BITS-1:0] wr_ptr, rd_ptr;
        logic [PTR_BITS:0] cnt;

        always_ff @(posedge clk)
        begin
            if (enq_en[f])
            begin
                mem[wr_ptr] <= enq_data[f];
            end
        end

        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                cnt <= '0;
            end
            else
            begin
                wr_ptr <= wr_ptr + PTR_BITS'(enq_en[f]);
                rd_ptr <= rd_ptr + PTR_BITS'(fifo_deq);
                cnt <= cnt + (PTR_BITS+1)'(enq_en[f]) - (PTR_BITS+1)'(fifo_deq);
            end
        end

        assign first[f] = mem[rd_ptr];
        assign not_empty[f] = (cnt != '0);
    end

    assign chk_almost_full = (fifo[0].cnt >= (PTR_BITS+1)'(AF_LEVEL));

    // ========================================================================
    // Comparison
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (state == RUN && fifo_deq)
        begin
            cnt_checked_rd <= cnt_checked_rd + counter_t'(1);
            if (checker_enabled && first[0] != first[1])
            begin
                raise_error <= 1'b1;
            end
        end
        if (reset || start)
        begin
            raise_error <= 1'b0;
            cnt_checked_rd <= '0;
        end
    end

endmodule

// ==== logic/request_port.sv ====
// Registered read and write requests, status line writes and response counters
`timescale 1ns/1ps

module request_port import traffic_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  run_state_e state,
    input  logic       rd_enabled,
    input  logic       wr_enabled,
    input  logic       chk_ready,
    input  logic       rd_almost_full,
    input  logic       wr_almost_full,
    input  line_addr_t rd_addr,
    input  logic       rd_checked,
    input  line_addr_t wr_addr,
    input  logic       wr_checked,
    input  line_data_t wr_data,
    input  line_addr_t status_addr,
    input  logic       rd_rsp_valid,
    input  logic       wr_rsp_valid,
    input  logic       start,
    output logic       rd_req_valid,
    output line_addr_t rd_req_addr,
    output logic       rd_req_checked,
    output logic       wr_req_valid,
    output line_addr_t wr_req_addr,
    output line_data_t wr_req_data,
    output logic       chk_wr_valid,
    output counter_t   cnt_rd_rsp,
    output counter_t   cnt_wr_rsp
);

    status_code_e status_code;

    assign status_code = (state == ERROR) ? STATUS_ERROR : STATUS_DONE;

    // ========================================================================
    // Reads
    // ========================================================================

    always_ff @(posedge clk)
    begin
        rd_req_addr <= rd_addr;
        rd_req_checked <= rd_checked;
        rd_req_valid <= (state == RUN) && rd_enabled && chk_ready && !rd_almost_full;

        if (reset)
        begin
            rd_req_valid <= 1'b0;
        end
    end

    // ========================================================================
    // Writes and status line
    // ========================================================================

    always_ff @(posedge clk)
    begin
        wr_req_addr <= wr_addr;
        wr_req_data <= wr_data;
        wr_req_valid <= 1'b0;
        chk_wr_valid <= 1'b0;

        if (!wr_almost_full)
        begin
            if (state == RUN)
            begin
                wr_req_valid <= chk_ready && wr_enabled;
                // Only checked lines update the tag RAM
                chk_wr_valid <= chk_ready && wr_enabled && wr_checked;
            end
            else if (state == TERMINATE || state == ERROR)
            begin
                wr_req_valid <= 1'b1;
                wr_req_addr <= status_addr;
                wr_req_data <= line_data_t'(status_code);
            end
        end

        if (reset)
        begin
            wr_req_valid <= 1'b0;
            chk_wr_valid <= 1'b0;
        end
    end

    // Response counters, cleared for every run
    always_ff @(posedge clk)
    begin
        cnt_rd_rsp <= cnt_rd_rsp + counter_t'(rd_rsp_valid);
        cnt_wr_rsp <= cnt_wr_rsp + counter_t'(wr_rsp_valid);

        if (reset || start)
        begin
            cnt_rd_rsp <= '0;
            cnt_wr_rsp <= '0;
        end
    end

endmodule

// ==== logic/write_data_gen.sv ====
// Bank of 32-bit LFSRs forming one random write line
`timescale 1ns/1ps

module write_data_gen import traffic_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output line_data_t wr_rand_data
);

    localparam int LFSR_COUNT = LINE_BITS / 32;

    logic [31:0] lfsr [LFSR_COUNT];

    for (genvar r = 0; r < LFSR_COUNT; r++)
    begin : g_lfsr
        // Seeds count up from 1 so each word differs
        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                lfsr[r] <= 32'(r + 1);
            end
            else
            begin
                lfsr[r] <= lfsr32_next(lfsr[r]);
            end
        end

        // Word r fills bits 32*r upward
        assign wr_rand_data[32*r +: 32] = lfsr[r];
    end

endmodule

// ==== logic/addr_gen.sv ====
// LFSR random address stream with checked and unchecked index mapping
`timescale 1ns/1ps

module addr_gen import traffic_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h1,
    parameter bit          FORCED_BIT = 1'b0
)
(
    input  logic       clk,
    input  logic       reset,
    input  line_addr_t mem_base,
    input  logic       rw_conflicts,
    output line_addr_t addr,
    output logic       addr_checked,
    output chk_idx_t   chk_idx,
    output chk_idx_t   chk_idx_q
);

    logic [31:0] lfsr;
    region_idx_t idx;

    // Free running, one step per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr <= SEED;
        end
        else
        begin
            lfsr <= lfsr32_next(lfsr);
        end
    end

    // Without conflicts reads and writes live on opposite values of bit 0
    always_comb
    begin
        idx = lfsr[REGION_BITS-1:0];
        if (!rw_conflicts)
        begin
            idx[0] = FORCED_BIT;
        end
    end

    // Mapped address, then one more stage on the tag index
    // so it lines up with the registered request
    always_ff @(posedge clk)
    begin
        addr <= mem_base + line_addr_t'(idx);
        addr_checked <= idx_is_checked(idx);
        chk_idx <= idx_to_chk(idx);
        chk_idx_q <= chk_idx;
    end

endmodule

// ==== logic/run_control.sv ====
// Run FSM, configuration registers and run-cycle countdown
`timescale 1ns/1ps

module run_control import traffic_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  counter_t   run_cycles,
    input  logic       enable_reads,
    input  logic       enable_writes,
    input  logic       enable_checker,
    input  logic       enable_rw_conflicts,
    input  logic       raise_error,
    input  logic       wr_almost_full,
    output run_state_e state,
    output logic       rd_enabled,
    output logic       wr_enabled,
    output logic       checker_enabled,
    output logic       rw_conflicts,
    output logic       run_busy
);

    counter_t cycles_rem;

    // ========================================================================
    // Configuration and countdown
    // ========================================================================

    always_ff @(posedge clk)
    begin
        // Count down to zero and stay there
        if (cycles_rem != '0)
        begin
            cycles_rem <= cycles_rem - counter_t'(1);
        end

        // Start loads a fresh run length and the enables
        if (start)
        begin
            cycles_rem <= run_cycles;
            rd_enabled <= enable_reads;
            wr_enabled <= enable_writes;
            checker_enabled <= enable_checker;
            rw_conflicts <= enable_rw_conflicts;
        end

        if (reset)
        begin
            cycles_rem <= '0;
            rd_enabled <= 1'b0;
            wr_enabled <= 1'b0;
            checker_enabled <= 1'b0;
            rw_conflicts <= 1'b0;
        end
    end

    // ========================================================================
    // Run state machine
    // ========================================================================

    always_ff @(posedge clk)
    begin
        case (state)
            IDLE:
            begin
                if (start)
                begin
                    state <= RUN;
                end
            end
            RUN:
            begin
                // An error wins over a normal end
                if (raise_error)
                begin
                    state <= ERROR;
                end
                else if (cycles_rem == '0)
                begin
                    state <= TERMINATE;
                end
            end
            default:
            begin
                // Status write goes out in this same cycle
                if (!wr_almost_full)
                begin
                    state <= IDLE;
                end
            end
        endcase

        if (reset)
        begin
            state <= IDLE;
        end
    end

    assign run_busy = (state != IDLE);

endmodule

// ==== logic/traffic_pkg.sv ====
// Shared widths, types, state and status enums, address mapping and tag helpers
package traffic_pkg;

    // Line and address widths
    localparam int LINE_BITS = 128;
    typedef logic [LINE_BITS-1:0] line_data_t;
    localparam int ADDR_BITS = 32;
    typedef logic [ADDR_BITS-1:0] line_addr_t;
    typedef logic [31:0] counter_t;
    localparam int TAG_BITS = 32;
    typedef logic [TAG_BITS-1:0] tag_t;

    // ========================================================================
    // Address mapping
    // ========================================================================

    // Random index is split as {checked_high, unchecked_middle, checked_low}
    localparam int REGION_BITS = 12;
    localparam int CHECKED_BITS = 8;
    localparam int CHECKED_LOW_BITS = 5;
    localparam int UNCHECKED_BITS = REGION_BITS - CHECKED_BITS;
    localparam int CHECKED_HIGH_BITS = CHECKED_BITS - CHECKED_LOW_BITS;
    typedef logic [REGION_BITS-1:0] region_idx_t;
    typedef logic [CHECKED_BITS-1:0] chk_idx_t;

    // Galois feedback for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // Bytes of a line that form its tag
    localparam int TAG_BYTE0 = 0;
    localparam int TAG_BYTE1 = 5;
    localparam int TAG_BYTE2 = 11;
    localparam int TAG_BYTE3 = 15;

    typedef enum logic [1:0] {IDLE, RUN, TERMINATE, ERROR} run_state_e;

    // Low bits of the status line
    typedef enum logic [1:0] {STATUS_DONE = 2'd1, STATUS_ERROR = 2'd2} status_code_e;

    // One LFSR step, shifting right
    function automatic logic [31:0] lfsr32_next(logic [31:0] v);
        return {1'b0, v[31:1]} ^ (v[0] ? LFSR_TAPS : 32'h0);
    endfunction

    // Checked only when the middle field is all zero
    function automatic logic idx_is_checked(region_idx_t idx);
        return idx[CHECKED_LOW_BITS +: UNCHECKED_BITS] == '0;
    endfunction

    // Tag RAM index is the high field above the low field
    function automatic chk_idx_t idx_to_chk(region_idx_t idx);
        return {idx[REGION_BITS-1 -: CHECKED_HIGH_BITS], idx[CHECKED_LOW_BITS-1:0]};
    endfunction

    // Byte 15 lands in the top tag byte and byte 0 in the bottom one
    function automatic tag_t line_to_tag(line_data_t v);
        return {v[8*TAG_BYTE3 +: 8], v[8*TAG_BYTE2 +: 8],
                v[8*TAG_BYTE1 +: 8], v[8*TAG_BYTE0 +: 8]};
    endfunction

endpackage
